// ==== hdl/bpred_pkg.sv ====
`default_nettype none

package bpred_pkg;

  // Address and data width of the core
  localparam int XLEN = 32;

  // Two-bit saturating counter, upper half predicts taken
  typedef enum logic [1:0] {
    strong_nt = 2'b00,
    weak_nt   = 2'b01,
    weak_t    = 2'b10,
    strong_t  = 2'b11
  } ctr_t;

  // One resolved instruction leaving EX
  typedef struct packed {
    logic            valid;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic [4:0]      rd;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] target;
    // Actual outcome
    logic            taken;
    // What fetch predicted for this instruction
    logic            pred_taken;
    logic [XLEN-1:0] pred_target;
  } ex_cf_t;

  // BTB write request
  typedef struct packed {
    logic            en;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] target;
    logic            taken;
    logic            is_ret;
    logic            is_jal;
  } btb_upd_t;

  // Fetch prediction
  typedef struct packed {
    logic            hit;
    logic            taken;
    logic            is_ret;
    logic [XLEN-1:0] target;
  } fetch_pred_t;

endpackage

`default_nettype wire

// ==== hdl/bpred_ex.sv ====
`timescale 1ns/1ns
`default_nettype none

// EX stage: BTB training and RAS push from one resolved record
module bpred_ex
  import bpred_pkg::*;
#(
  parameter int BTB_ENABLE = 1
) (
  input  ex_cf_t          ex,
  output btb_upd_t        btb_upd,
  output logic            ras_push,
  output logic [XLEN-1:0] ras_push_addr
);

  logic is_call;

  // Calls link through x1 or x5
  assign is_call       = (ex.is_jal || ex.is_jalr) && ((ex.rd == 5'd1) || (ex.rd == 5'd5));
  // RAS keeps working with the BTB off
  assign ras_push      = ex.valid && is_call;
  assign ras_push_addr = ex.pc + XLEN'(4);

  if (BTB_ENABLE != 0) begin : g_btb_upd
    logic is_return;
    logic is_predictable;
    logic target_aligned;

    // Return or tail call, rd is x0
    assign is_return      = ex.is_jalr && (ex.rd == 5'd0);
    // Plain JALR targets come from registers, left out
    assign is_predictable = ex.is_branch || ex.is_jal || is_return;
    // Misaligned targets would trap
    assign target_aligned = (ex.target[1:0] == 2'b00);

    assign btb_upd.en     = ex.valid && is_predictable && target_aligned;
    assign btb_upd.pc     = ex.pc;
    assign btb_upd.target = ex.target;
    assign btb_upd.is_ret = is_return;
    assign btb_upd.is_jal = ex.is_jal;
    // Unconditional jumps always train toward taken
    assign btb_upd.taken  = (ex.is_jal || is_return) ? 1'b1 : ex.taken;
  end else begin : g_no_btb_upd
    // BTB never written
    assign btb_upd = '0;
  end

endmodule

`default_nettype wire

// ==== hdl/bpred_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

// MEM stage misprediction check one cycle behind EX
module bpred_mem
  import bpred_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  ex_cf_t ex,
  output logic   mispredicted
);

  logic   valid_q;
  ex_cf_t ex_q;
  logic   is_cf;
  logic   act_taken;
  logic   dir_miss;
  logic   tgt_miss;

  // Registered record valid
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= ex.valid;
    end
  end

  // Registered record payload
  always_ff @(posedge clk) begin
    ex_q <= ex;
  end

  // Control transfers only
  assign is_cf     = ex_q.is_branch || ex_q.is_jal || ex_q.is_jalr;

  // Jumps are always taken
  assign act_taken = ex_q.is_branch ? ex_q.taken : 1'b1;

  // Direction wrong
  assign dir_miss  = (act_taken != ex_q.pred_taken);

  // Taken but predicted elsewhere
  assign tgt_miss  = act_taken && (ex_q.pred_target != ex_q.target);

  assign mispredicted = valid_q && is_cf && (dir_miss || tgt_miss);

endmodule

`default_nettype wire

// ==== hdl/bpred_btb.sv ====
`timescale 1ns/1ns
`default_nettype none

// Direct-mapped branch target buffer
module bpred_btb
  import bpred_pkg::*;
#(
  parameter int BTB_DEPTH = 16
) (
  input  logic            clk,
  input  logic            reset,
  input  logic [XLEN-1:0] lookup_pc,
  input  btb_upd_t        upd,
  output logic            hit,
  output logic            taken,
  output logic            is_ret,
  output logic [XLEN-1:0] target
);

  localparam int IDX_W = $clog2(BTB_DEPTH);
  // Word aligned pc, bits 1:0 not stored
  localparam int TAG_W = XLEN - IDX_W - 2;

  logic [BTB_DEPTH-1:0] valid_q;
  logic [TAG_W-1:0]     tag_mem [BTB_DEPTH];
  logic [XLEN-1:0]      tgt_mem [BTB_DEPTH];
  logic                 ret_mem [BTB_DEPTH];
  logic                 jal_mem [BTB_DEPTH];
  ctr_t                 ctr_mem [BTB_DEPTH];

  logic [IDX_W-1:0] lidx;
  logic [TAG_W-1:0] ltag;
  logic [IDX_W-1:0] uidx;
  logic [TAG_W-1:0] utag;
  logic             upd_hit;
  ctr_t             ctr_new;

  // Saturate toward the actual outcome
  function automatic ctr_t ctr_train(input ctr_t c, input logic t);
    ctr_t n;
    unique case (c)
      strong_nt: n = t ? weak_nt : strong_nt;
      weak_nt:   n = t ? weak_t : strong_nt;
      weak_t:    n = t ? strong_t : weak_nt;
      default:   n = t ? strong_t : weak_t;
    endcase
    return n;
  endfunction

  // Lookup side
  assign lidx = lookup_pc[IDX_W+1:2];
  assign ltag = lookup_pc[XLEN-1:IDX_W+2];

  assign hit    = valid_q[lidx] && (tag_mem[lidx] == ltag);
  // JAL entries are always taken
  assign taken  = jal_mem[lidx] || (ctr_mem[lidx] inside {weak_t, strong_t});
  assign is_ret = ret_mem[lidx];
  assign target = tgt_mem[lidx];

  // Update side
  assign uidx    = upd.pc[IDX_W+1:2];
  assign utag    = upd.pc[XLEN-1:IDX_W+2];
  assign upd_hit = valid_q[uidx] && (tag_mem[uidx] == utag);

  always_comb begin
    if (upd.is_jal) begin
      ctr_new = strong_t;
    end else if (upd_hit) begin
      // Same instruction, keep training
      ctr_new = ctr_train(ctr_mem[uidx], upd.taken);
    end else begin
      // New or aliased entry starts weak
      ctr_new = upd.taken ? weak_t : weak_nt;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else if (upd.en) begin
      valid_q[uidx] <= 1'b1;
    end
  end

  // Entry payload, flags follow the latest writer
  always_ff @(posedge clk) begin
    if (upd.en) begin
      tag_mem[uidx] <= utag;
      tgt_mem[uidx] <= upd.target;
      ret_mem[uidx] <= upd.is_ret;
      jal_mem[uidx] <= upd.is_jal;
      ctr_mem[uidx] <= ctr_new;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/bpred_ras.sv ====
`timescale 1ns/1ns
`default_nettype none

// Return address stack, circular with saturating count
module bpred_ras
  import bpred_pkg::*;
#(
  parameter int RAS_DEPTH = 4
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            push,
  input  logic [XLEN-1:0] push_addr,
  input  logic            pop,
  output logic [XLEN-1:0] top,
  output logic            empty
);

  localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
  localparam int CNT_W = $clog2(RAS_DEPTH + 1);

  logic [XLEN-1:0]  stack_mem [RAS_DEPTH];
  logic [PTR_W-1:0] ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic [PTR_W-1:0] ptr_push;
  logic [CNT_W-1:0] cnt_push;
  logic [PTR_W-1:0] ptr_next;
  logic [CNT_W-1:0] cnt_next;

  always_comb begin
    ptr_push = ptr_q;
    cnt_push = cnt_q;
    // Push first, overwrites the oldest slot when full
    if (push) begin
      ptr_push = (ptr_q == PTR_W'(RAS_DEPTH - 1)) ? '0 : ptr_q + 1'b1;
      if (cnt_q != CNT_W'(RAS_DEPTH)) begin
        cnt_push = cnt_q + 1'b1;
      end
    end
    ptr_next = ptr_push;
    cnt_next = cnt_push;
    // Then pop, ignored on an empty stack
    if (pop && (cnt_push != '0)) begin
      ptr_next = (ptr_push == '0) ? PTR_W'(RAS_DEPTH - 1) : ptr_push - 1'b1;
      cnt_next = cnt_push - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr_q <= '0;
      cnt_q <= '0;
    end else begin
      ptr_q <= ptr_next;
      cnt_q <= cnt_next;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      stack_mem[ptr_push] <= push_addr;
    end
  end

  // Top is only meaningful when not empty
  assign top   = stack_mem[ptr_q];
  assign empty = (cnt_q == '0);

endmodule

`default_nettype wire

// ==== hdl/bpred_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

// Fetch prediction from the BTB lookup and the RAS top
module bpred_fetch
  import bpred_pkg::*;
(
  input  logic            btb_hit,
  input  logic            btb_taken,
  input  logic            btb_is_ret,
  input  logic [XLEN-1:0] btb_target,
  input  logic [XLEN-1:0] ras_top,
  input  logic            ras_empty,
  output fetch_pred_t     pred,
  output logic            ras_pop
);

  logic ret_sel;

  // Return entry with an address on the stack
  assign ret_sel = btb_hit && btb_is_ret && !ras_empty;

  always_comb begin
    pred.hit    = btb_hit;
    pred.is_ret = btb_hit && btb_is_ret;
    if (ret_sel) begin
      // Return goes to the stacked address
      pred.taken  = 1'b1;
      pred.target = ras_top;
    end else if (btb_hit) begin
      pred.taken  = btb_taken;
      pred.target = btb_target;
    end else begin
      // Miss falls through
      pred.taken  = 1'b0;
      pred.target = '0;
    end
  end

  // Consumed return address leaves the stack
  assign ras_pop = ret_sel;

endmodule

`default_nettype wire

// ==== hdl/bpred_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// Branch prediction subsystem
module bpred_top
  import bpred_pkg::*;
#(
  parameter int BTB_DEPTH  = 16,
  parameter int RAS_DEPTH  = 4,
  parameter int BTB_ENABLE = 1
) (
  input  logic            clk,
  input  logic            reset,
  input  logic [XLEN-1:0] fetch_pc,
  input  ex_cf_t          ex,
  output fetch_pred_t     pred,
  output logic            mispredicted
);

  btb_upd_t        btb_upd;
  logic            ras_push;
  logic [XLEN-1:0] ras_push_addr;
  logic            ras_pop;
  logic [XLEN-1:0] ras_top;
  logic            ras_empty;
  logic            btb_hit;
  logic            btb_taken;
  logic            btb_is_ret;
  logic [XLEN-1:0] btb_target;

  // EX side training
  bpred_ex #(
    .BTB_ENABLE(BTB_ENABLE)
  ) i_bpred_ex (
    .ex           (ex),
    .btb_upd      (btb_upd),
    .ras_push     (ras_push),
    .ras_push_addr(ras_push_addr)
  );

  // Check one stage later
  bpred_mem i_bpred_mem (
    .clk         (clk),
    .reset       (reset),
    .ex          (ex),
    .mispredicted(mispredicted)
  );

  bpred_btb #(
    .BTB_DEPTH(BTB_DEPTH)
  ) i_bpred_btb (
    .clk      (clk),
    .reset    (reset),
    .lookup_pc(fetch_pc),
    .upd      (btb_upd),
    .hit      (btb_hit),
    .taken    (btb_taken),
    .is_ret   (btb_is_ret),
    .target   (btb_target)
  );

  bpred_ras #(
    .RAS_DEPTH(RAS_DEPTH)
  ) i_bpred_ras (
    .clk      (clk),
    .reset    (reset),
    .push     (ras_push),
    .push_addr(ras_push_addr),
    .pop      (ras_pop),
    .top      (ras_top),
    .empty    (ras_empty)
  );

  // Fetch side prediction
  bpred_fetch i_bpred_fetch (
    .btb_hit   (btb_hit),
    .btb_taken (btb_taken),
    .btb_is_ret(btb_is_ret),
    .btb_target(btb_target),
    .ras_top   (ras_top),
    .ras_empty (ras_empty),
    .pred      (pred),
    .ras_pop   (ras_pop)
  );

endmodule

`default_nettype wire

// ==== bench/bpred_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module bpred_tb
  import bpred_pkg::*;
();

  localparam int BTB_DEPTH = 16;
  localparam int RAS_DEPTH = 4;
  localparam int IDX_W     = $clog2(BTB_DEPTH);
  localparam int N_RESET   = 20;
  localparam int N_TRAIN   = 400;
  localparam int N_FILTER  = 100;
  localparam int N_RAS     = 300;
  localparam int N_MISP    = 400;
  // Training and filter records take a record step plus a fetch step
  localparam int N_CYCLES  = 16 + N_RESET + 2 * N_TRAIN + 2 * N_FILTER + N_RAS + N_MISP + 1;
  localparam int TIMEOUT   = 2 * N_CYCLES + 100;

  typedef enum {k_none, k_branch, k_jal, k_jalr} kind_t;

  logic            clk;
  logic            reset;
  logic [XLEN-1:0] fetch_pc;
  ex_cf_t          ex;
  fetch_pred_t     pred;
  logic            mispredicted;

  integer     seed;
  int         cycle_cnt;
  // Expected mispredicted for the record one cycle back
  logic       mispred_pend;
  logic [31:0] r;
  logic [XLEN-1:0] pc;
  ex_cf_t     rec;

  // Model BTB and RAS
  logic            m_valid [BTB_DEPTH];
  logic [XLEN-1:0] m_tag   [BTB_DEPTH];
  logic [XLEN-1:0] m_tgt   [BTB_DEPTH];
  logic            m_ret   [BTB_DEPTH];
  ctr_t            m_ctr   [BTB_DEPTH];
  logic [XLEN-1:0] m_ras   [$];

  bpred_top #(
    .BTB_DEPTH (BTB_DEPTH),
    .RAS_DEPTH (RAS_DEPTH),
    .BTB_ENABLE(1)
  ) i_bpred_top (
    .clk         (clk),
    .reset       (reset),
    .fetch_pc    (fetch_pc),
    .ex          (ex),
    .pred        (pred),
    .mispredicted(mispredicted)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Timeout: stimulus still running after %0d cycles", cycle_cnt);
      $display(">>> FAIL");
      $fatal(1, "run stopped by cycle limit");
    end
  end

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  // Four tags per index region so entries alias
  function automatic logic [XLEN-1:0] pick_pc(input logic [XLEN-1:0] base,
                                              input logic [31:0] v);
    return base | XLEN'({v[5:4], 2'b00, v[3:2], 2'b00});
  endfunction

  // Return pcs on indices 8 to 11 with a single tag
  function automatic logic [XLEN-1:0] ret_pc(input logic [31:0] v);
    return 32'h0004_0020 | XLEN'({v[3:2], 2'b00});
  endfunction

  // Resolved record with random fetch-side guesses
  function automatic ex_cf_t make_rec(input kind_t kind, input logic [4:0] rd,
                                      input logic [XLEN-1:0] rpc,
                                      input logic [XLEN-1:0] target, input logic taken);
    ex_cf_t      e;
    logic [31:0] v;
    v             = rnd();
    e             = '0;
    e.valid       = 1'b1;
    e.is_branch   = (kind == k_branch);
    e.is_jal      = (kind == k_jal);
    e.is_jalr     = (kind == k_jalr);
    e.rd          = rd;
    e.pc          = rpc;
    e.target      = target;
    e.taken       = taken;
    e.pred_taken  = v[0];
    // Half the time fetch guessed the right target
    e.pred_target = v[1] ? target : (rnd() & ~32'h3);
    return e;
  endfunction

  // Expected misprediction from the MEM rule
  function automatic logic mispred_rule(input ex_cf_t e);
    logic act;
    act = e.is_branch ? e.taken : 1'b1;
    if (!e.valid || !(e.is_branch || e.is_jal || e.is_jalr)) begin
      return 1'b0;
    end
    return (act != e.pred_taken) || (act && (e.pred_target != e.target));
  endfunction

  task automatic model_predict(input logic [XLEN-1:0] fpc, output fetch_pred_t p,
                               output logic pop);
    int idx;
    idx = (fpc >> 2) % BTB_DEPTH;
    p   = '0;
    pop = 1'b0;
    if (m_valid[idx] && (m_tag[idx] == (fpc >> (IDX_W + 2)))) begin
      p.hit    = 1'b1;
      p.is_ret = m_ret[idx];
      if (m_ret[idx] && (m_ras.size() > 0)) begin
        p.taken  = 1'b1;
        p.target = m_ras[$];
        pop      = 1'b1;
      end else begin
        p.taken  = (m_ctr[idx] == weak_t) || (m_ctr[idx] == strong_t);
        p.target = m_tgt[idx];
      end
    end
  endtask

  task automatic model_update(input ex_cf_t e, input logic pop);
    int   idx;
    logic is_ret;
    logic tk;
    logic same;
    idx    = (e.pc >> 2) % BTB_DEPTH;
    is_ret = e.is_jalr && (e.rd == 5'd0);
    tk     = (e.is_jal || is_ret) ? 1'b1 : e.taken;
    same   = m_valid[idx] && (m_tag[idx] == (e.pc >> (IDX_W + 2)));
    if (e.valid && (e.is_branch || e.is_jal || is_ret) && (e.target[1:0] == 2'b00)) begin
      if (e.is_jal) begin
        m_ctr[idx] = strong_t;
      end else if (same) begin
        // Saturating step toward the outcome
        if (tk && (m_ctr[idx] != strong_t)) begin
          m_ctr[idx] = ctr_t'(m_ctr[idx] + 1);
        end else if (!tk && (m_ctr[idx] != strong_nt)) begin
          m_ctr[idx] = ctr_t'(m_ctr[idx] - 1);
        end
      end else begin
        m_ctr[idx] = tk ? weak_t : weak_nt;
      end
      m_valid[idx] = 1'b1;
      m_tag[idx]   = e.pc >> (IDX_W + 2);
      m_tgt[idx]   = e.target;
      m_ret[idx]   = is_ret;
    end
    // Push first and drop the oldest on overflow
    if (e.valid && (e.is_jal || e.is_jalr) && ((e.rd == 5'd1) || (e.rd == 5'd5))) begin
      m_ras.push_back(e.pc + 32'd4);
      if (m_ras.size() > RAS_DEPTH) begin
        void'(m_ras.pop_front());
      end
    end
    if (pop && (m_ras.size() > 0)) begin
      void'(m_ras.pop_back());
    end
  endtask

  task automatic check_pred(input fetch_pred_t got, input fetch_pred_t exp,
                            input logic [XLEN-1:0] fpc);
    if (got !== exp) begin
      $display("Error at %0t ns: pred for pc %h is hit %b taken %b ret %b target %h",
               $time, fpc, got.hit, got.taken, got.is_ret, got.target);
      $display("  expected hit %b taken %b ret %b target %h",
               exp.hit, exp.taken, exp.is_ret, exp.target);
      $display(">>> FAIL");
      $fatal(1, "prediction mismatch");
    end
  endtask

  task automatic check_mispred(input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: mispredicted is %b, expected %b", $time, got, exp);
      $display(">>> FAIL");
      $fatal(1, "misprediction flag mismatch");
    end
  endtask

  // Drive fetch and record for one cycle, check mid cycle and advance the model
  task automatic step(input logic [XLEN-1:0] fpc, input ex_cf_t e);
    fetch_pred_t exp_pred;
    logic        exp_pop;
    @(posedge clk);
    fetch_pc <= fpc;
    ex       <= e;
    @(negedge clk);
    model_predict(fpc, exp_pred, exp_pop);
    check_pred(pred, exp_pred, fpc);
    check_mispred(mispredicted, mispred_pend);
    mispred_pend = mispred_rule(e);
    model_update(e, exp_pop);
  endtask

  initial begin
    seed         = 8477;
    clk          = 1'b0;
    reset        = 1'b1;
    fetch_pc     = '0;
    ex           = '0;
    cycle_cnt    = 0;
    mispred_pend = 1'b0;
    for (int i = 0; i < BTB_DEPTH; i++) begin
      m_valid[i] = 1'b0;
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // Empty tables right after reset
    for (int i = 0; i < N_RESET; i++) begin
      step(pick_pc(32'h0000_1000, rnd()), '0);
    end

    // Branch training with each record followed by a fetch of its pc
    for (int i = 0; i < N_TRAIN; i++) begin
      r  = rnd();
      pc = pick_pc(32'h0000_1000, rnd());
      step(pick_pc(32'h0000_1000, rnd()),
           make_rec(k_branch, r[8:4], pc, rnd() & ~32'h3, r[0]));
      step(pc, '0);
    end

    // Filtered records on indices 4 to 7 must not train
    for (int i = 0; i < N_FILTER; i++) begin
      r  = rnd();
      pc = pick_pc(32'h0003_0010, rnd());
      case (r[1:0])
        2'd0: rec = make_rec(r[2] ? k_jal : k_branch, 5'd0, pc,
                             (rnd() & ~32'h3) | XLEN'(r[4:3] | 2'b01), 1'b1);
        2'd1: rec = make_rec(k_jalr, (r[8:4] == 5'd0) ? 5'd2 : r[8:4], pc,
                             rnd() & ~32'h3, 1'b1);
        2'd2: rec = make_rec(k_none, r[8:4], pc, rnd() & ~32'h3, r[2]);
        default: begin
          rec       = make_rec(k_branch, 5'd0, pc, rnd() & ~32'h3, r[2]);
          rec.valid = 1'b0;
        end
      endcase
      step(pick_pc(32'h0000_1000, rnd()), rec);
      step(pc, '0);
    end

    // Calls, returns and return fetches mixed
    for (int i = 0; i < N_RAS; i++) begin
      r = rnd();
      case (r[1:0])
        2'd0, 2'd1: rec = make_rec(r[2] ? k_jal : k_jalr, r[3] ? 5'd1 : 5'd5,
                                   pick_pc(32'h0002_0030, rnd()), rnd() & ~32'h3, 1'b1);
        2'd2: rec = make_rec(k_jalr, 5'd0, ret_pc(rnd()), rnd() & ~32'h3, 1'b1);
        default: rec = '0;
      endcase
      // Few return fetches in the first half so the stack overflows
      // More in the second half so it drains and empties
      if ((i < N_RAS / 2) ? (r[5:4] == 2'd0) : (r[5:4] != 2'd0)) begin
        step(ret_pc(rnd()), rec);
      end else begin
        step(pick_pc(32'h0002_0030, rnd()), rec);
      end
    end

    // Random mix of kinds for the misprediction check
    for (int i = 0; i < N_MISP; i++) begin
      r         = rnd();
      rec       = make_rec(kind_t'(r[1:0]), r[8:4], pick_pc(32'h0000_1000, rnd()),
                           rnd() & ~32'h3, r[2]);
      rec.valid = |r[11:9];
      step(pick_pc(32'h0000_1000, rnd()), rec);
    end

    // Drain the last flag
    step(pick_pc(32'h0000_1000, rnd()), '0);

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/bpred_pkg.sv
hdl/bpred_ex.sv
hdl/bpred_mem.sv
hdl/bpred_btb.sv
hdl/bpred_ras.sv
hdl/bpred_fetch.sv
hdl/bpred_top.sv
bench/bpred_tb.sv
